//--- verilog/cpu_pkg.sv
package cpu_pkg;

    localparam int WORD_W   = 16;
    localparam int NUM_REGS = 4;

    // instruction fields
    localparam int OP_MSB   = 15;
    localparam int OP_LSB   = 12;
    localparam int RS_MSB   = 11;
    localparam int RS_LSB   = 10;
    localparam int RT_MSB   = 9;
    localparam int RT_LSB   = 8;
    localparam int RD_MSB   = 7;
    localparam int RD_LSB   = 6;
    localparam int FUNC_MSB = 5;
    localparam int FUNC_LSB = 0;
    localparam int IMM_MSB  = 7;
    localparam int IMM_LSB  = 0;
    localparam int TGT_MSB  = 11;
    localparam int TGT_LSB  = 0;

    localparam logic [5:0] FUNC_ADD = 6'd0;
    localparam logic [5:0] FUNC_SUB = 6'd1;
    localparam logic [5:0] FUNC_AND = 6'd2;
    localparam logic [5:0] FUNC_ORR = 6'd3;
    localparam logic [5:0] FUNC_WWD = 6'd28;
    localparam logic [5:0] FUNC_HLT = 6'd29;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcode_t;

    // first four follow the func code order
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_PASS_B, ALU_CMP
    } alu_op_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src_imm;
        alu_op_t alu_op;
        logic    is_branch;
        logic    branch_on_eq;
        logic    is_jump;
        logic    is_wwd;
        logic    is_halt;
        logic    valid;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    pc;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;
        reg_idx_t dest;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;
        word_t    store_data;
        word_t    target;
        logic     taken;
        reg_idx_t dest;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;
        word_t    load_data;
        reg_idx_t dest;
    } mem_wb_t;

endpackage

//--- verilog/pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= '0; // bubble, valid and enables all low
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

//--- verilog/decode_unit.sv
`timescale 1ns/1ns

module decode_unit import cpu_pkg::*; (
    input  word_t    instr,
    output ctrl_t    ctrl,
    output word_t    imm,
    output reg_idx_t rs,
    output reg_idx_t rt,
    output reg_idx_t dest,
    output logic     reads_rs,
    output logic     reads_rt
);

    opcode_t    op;
    logic [5:0] func;
    word_t      imm_sext;
    word_t      imm_zext;

    assign op       = opcode_t'(instr[OP_MSB:OP_LSB]);
    assign func     = instr[FUNC_MSB:FUNC_LSB];
    assign rs       = instr[RS_MSB:RS_LSB];
    assign rt       = instr[RT_MSB:RT_LSB];
    assign imm_sext = {{8{instr[IMM_MSB]}}, instr[IMM_MSB:IMM_LSB]};
    assign imm_zext = {8'h00, instr[IMM_MSB:IMM_LSB]};

    always_comb begin
        ctrl        = '0;
        ctrl.valid  = 1'b1; // unknown encodings retire as nops
        ctrl.alu_op = ALU_ADD;
        imm         = '0;
        dest        = rt;
        reads_rs    = 1'b0;
        reads_rt    = 1'b0;
        case (op)
            OP_RTYPE: begin
                dest = instr[RD_MSB:RD_LSB];
                case (func)
                    FUNC_ADD, FUNC_SUB, FUNC_AND, FUNC_ORR: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = alu_op_t'({1'b0, func[1:0]});
                        reads_rs       = 1'b1;
                        reads_rt       = 1'b1;
                    end
                    FUNC_WWD: begin
                        ctrl.is_wwd      = 1'b1;
                        ctrl.alu_src_imm = 1'b1; // rs + 0 carries the value
                        reads_rs         = 1'b1;
                    end
                    FUNC_HLT: ctrl.is_halt = 1'b1;
                    default: ;
                endcase
            end
            OP_ADI, OP_ORI, OP_LWD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read    = (op == OP_LWD);
                ctrl.mem_to_reg  = (op == OP_LWD);
                ctrl.alu_op      = (op == OP_ORI) ? ALU_OR : ALU_ADD;
                imm              = (op == OP_ORI) ? imm_zext : imm_sext;
                reads_rs         = 1'b1;
            end
            OP_LHI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_PASS_B;
                imm              = {instr[IMM_MSB:IMM_LSB], 8'h00};
            end
            OP_SWD: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm              = imm_sext;
                reads_rs         = 1'b1;
                reads_rt         = 1'b1; // store data
            end
            OP_BNE, OP_BEQ: begin
                ctrl.is_branch    = 1'b1;
                ctrl.branch_on_eq = (op == OP_BEQ);
                ctrl.alu_op       = ALU_CMP;
                imm               = imm_sext;
                reads_rs          = 1'b1;
                reads_rt          = 1'b1;
            end
            OP_JMP: begin
                ctrl.is_jump = 1'b1;
                imm          = {4'h0, instr[TGT_MSB:TGT_LSB]};
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ns

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    input  logic     we,
    input  reg_idx_t wa,
    input  word_t    wd,
    output word_t    rs_data,
    output word_t    rt_data
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // write-through covers the writeback stage
    assign rs_data = (we && wa == rs) ? wd : regs[rs];
    assign rt_data = (we && wa == rt) ? wd : regs[rt];

endmodule

//--- verilog/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit import cpu_pkg::*; (
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    input  logic     reads_rs,
    input  logic     reads_rt,
    input  id_ex_t   id_ex,
    input  ex_mem_t  ex_mem,
    output logic     stall,
    output logic     flush
);

    logic ex_wr;
    logic mem_wr;
    logic rs_hit;
    logic rt_hit;

    assign ex_wr  = id_ex.ctrl.valid & id_ex.ctrl.reg_write;
    assign mem_wr = ex_mem.ctrl.valid & ex_mem.ctrl.reg_write;

    // no forwarding, so wait until the producer reaches writeback
    assign rs_hit = (ex_wr && id_ex.dest == rs) || (mem_wr && ex_mem.dest == rs);
    assign rt_hit = (ex_wr && id_ex.dest == rt) || (mem_wr && ex_mem.dest == rt);
    assign stall  = (reads_rs & rs_hit) | (reads_rt & rt_hit);

    assign flush = ex_mem.taken | ex_mem.ctrl.is_jump; // resolved in mem stage

endmodule

//--- verilog/execute_unit.sv
`timescale 1ns/1ns

module execute_unit import cpu_pkg::*; (
    input  id_ex_t  id_ex,
    output ex_mem_t ex_mem
);

    word_t op_a;
    word_t op_b;
    word_t alu_res;

    assign op_a = id_ex.rs_val;
    assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rt_val;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_PASS_B: alu_res = op_b;
            ALU_CMP:    alu_res = word_t'(op_a == op_b); // equal flag in bit 0
            default:    alu_res = op_a + op_b;
        endcase
    end

    always_comb begin
        ex_mem.ctrl       = id_ex.ctrl;
        ex_mem.alu_result = alu_res;
        ex_mem.store_data = id_ex.rt_val;
        ex_mem.dest       = id_ex.dest;
        ex_mem.taken      = id_ex.ctrl.is_branch & (alu_res[0] == id_ex.ctrl.branch_on_eq);
        if (id_ex.ctrl.is_jump) begin
            // page bits of the jump's own pc
            ex_mem.target = {id_ex.pc[WORD_W-1:TGT_MSB+1], id_ex.imm[TGT_MSB:0]};
        end else begin
            ex_mem.target = id_ex.pc + 16'd1 + id_ex.imm;
        end
    end

endmodule

//--- verilog/cpu_core.sv
`timescale 1ns/1ns

module cpu_core import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    output word_t i_addr,
    input  word_t i_data,
    output logic  d_read,
    output logic  d_write,
    output word_t d_addr,
    output word_t d_wdata,
    input  word_t d_rdata,
    output word_t output_port,
    output logic  output_valid,
    output word_t num_inst,
    output logic  halted
);

    word_t    pc;
    if_id_t   if_id_d, if_id_q;
    id_ex_t   id_ex_d, id_ex_q;
    ex_mem_t  ex_mem_d, ex_mem_q;
    mem_wb_t  mem_wb_d, mem_wb_q;

    ctrl_t    dec_ctrl;
    word_t    dec_imm;
    reg_idx_t dec_rs, dec_rt, dec_dest;
    logic     dec_reads_rs, dec_reads_rt;
    word_t    rs_data, rt_data, wb_data;

    logic     hz_stall, hz_flush;
    logic     redirect;
    logic     halting;
    logic     wb_valid;

    // HLT in writeback freezes everything from this cycle on
    assign halting  = halted | (mem_wb_q.ctrl.valid & mem_wb_q.ctrl.is_halt);
    assign redirect = hz_flush & ~halting;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (!halting) begin
            if (redirect) begin
                pc <= ex_mem_q.target;
            end else if (!hz_stall) begin
                pc <= pc + 16'd1;
            end
        end
    end

    assign i_addr  = pc;
    assign if_id_d = '{valid: 1'b1, pc: pc, instr: i_data};

    pipe_reg #(.payload_t(if_id_t)) if_id_i (
        .clk, .reset,
        .stall(hz_stall | halting),
        .flush(redirect),
        .d(if_id_d),
        .q(if_id_q)
    );

    decode_unit decode_i (
        .instr(if_id_q.instr), .ctrl(dec_ctrl), .imm(dec_imm),
        .rs(dec_rs), .rt(dec_rt), .dest(dec_dest),
        .reads_rs(dec_reads_rs), .reads_rt(dec_reads_rt)
    );

    reg_file reg_file_i (
        .clk, .reset,
        .rs(dec_rs), .rt(dec_rt),
        .we(wb_valid & mem_wb_q.ctrl.reg_write),
        .wa(mem_wb_q.dest), .wd(wb_data),
        .rs_data, .rt_data
    );

    hazard_unit hazard_i (
        .rs(dec_rs), .rt(dec_rt),
        .reads_rs(dec_reads_rs & if_id_q.valid),
        .reads_rt(dec_reads_rt & if_id_q.valid),
        .id_ex(id_ex_q), .ex_mem(ex_mem_q),
        .stall(hz_stall), .flush(hz_flush)
    );

    always_comb begin
        id_ex_d.ctrl   = if_id_q.valid ? dec_ctrl : '0;
        id_ex_d.pc     = if_id_q.pc;
        id_ex_d.rs_val = rs_data;
        id_ex_d.rt_val = rt_data;
        id_ex_d.imm    = dec_imm;
        id_ex_d.dest   = dec_dest;
    end

    pipe_reg #(.payload_t(id_ex_t)) id_ex_i (
        .clk, .reset,
        .stall(halting),
        .flush(redirect | (hz_stall & ~halting)), // stall drops a bubble here
        .d(id_ex_d),
        .q(id_ex_q)
    );

    execute_unit execute_i (.id_ex(id_ex_q), .ex_mem(ex_mem_d));

    pipe_reg #(.payload_t(ex_mem_t)) ex_mem_i (
        .clk, .reset,
        .stall(halting),
        .flush(redirect),
        .d(ex_mem_d),
        .q(ex_mem_q)
    );

    // memory stage, younger ops behind a halt never reach the bus
    assign d_read  = ex_mem_q.ctrl.mem_read & ~halting;
    assign d_write = ex_mem_q.ctrl.mem_write & ~halting;
    assign d_addr  = ex_mem_q.alu_result;
    assign d_wdata = ex_mem_q.store_data;

    always_comb begin
        mem_wb_d.ctrl       = ex_mem_q.ctrl;
        mem_wb_d.alu_result = ex_mem_q.alu_result;
        mem_wb_d.load_data  = d_rdata;
        mem_wb_d.dest       = ex_mem_q.dest;
    end

    pipe_reg #(.payload_t(mem_wb_t)) mem_wb_i (
        .clk, .reset,
        .stall(halting),
        .flush(1'b0),
        .d(mem_wb_d),
        .q(mem_wb_q)
    );

    // writeback
    assign wb_valid     = mem_wb_q.ctrl.valid & ~halted;
    assign wb_data      = mem_wb_q.ctrl.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_result;
    assign output_port  = mem_wb_q.alu_result;
    assign output_valid = wb_valid & mem_wb_q.ctrl.is_wwd;

    always_ff @(posedge clk) begin
        if (reset) begin
            num_inst <= '0;
            halted   <= 1'b0;
        end else if (wb_valid) begin
            num_inst <= num_inst + 16'd1;
            if (mem_wb_q.ctrl.is_halt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

//--- verif/cpu_assert.sv
`timescale 1ns/1ns

module cpu_assert import cpu_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  d_read,
    input logic  d_write,
    input logic  output_valid,
    input logic  halted,
    input word_t num_inst
);

    int fail_rw    = 0;
    int fail_halt  = 0;
    int fail_count = 0;
    int fail_out   = 0;

    assert property (@(posedge clk) disable iff (reset) !(d_read && d_write))
        else begin
            fail_rw++;
            $error("d_read and d_write are high in the same cycle");
        end

    assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else begin
            fail_halt++;
            $error("halted fell without a reset");
        end

    assert property (@(posedge clk) disable iff (reset) num_inst >= $past(num_inst))
        else begin
            fail_count++;
            $error("num_inst decreased without a reset");
        end

    assert property (@(posedge clk) disable iff (reset) halted |-> !output_valid)
        else begin
            fail_out++;
            $error("output_valid is high while halted");
        end

endmodule

bind cpu_core cpu_assert cpu_assert_i (.*);

//--- verif/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// instruction-level interpreter over imem, fills the expected queues
task automatic run_model();
    word_t    r [NUM_REGS];
    word_t    mem [256];
    word_t    pc;
    word_t    next_pc;
    word_t    ins;
    word_t    simm;
    word_t    addr;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    int       steps;
    bit       done;
    for (int a = 0; a < 256; a++) begin
        mem[a] = fill_word(8'(a));
    end
    for (int i = 0; i < NUM_REGS; i++) begin
        r[i] = '0;
    end
    exp_wwd.delete();
    exp_st_addr.delete();
    exp_st_data.delete();
    exp_ld_addr.delete();
    exp_count = '0;
    pc        = '0;
    done      = 1'b0;
    steps     = 0;
    while (!done && steps < 1000) begin
        ins       = imem[pc[7:0]];
        rs        = ins[11:10];
        rt        = ins[9:8];
        rd        = ins[7:6];
        simm      = {{8{ins[7]}}, ins[7:0]};
        addr      = r[rs] + simm;
        next_pc   = pc + 16'd1;
        exp_count = exp_count + 16'd1;
        steps++;
        case (ins[15:12])
            OP_RTYPE: begin
                case (ins[5:0])
                    FUNC_ADD: r[rd] = r[rs] + r[rt];
                    FUNC_SUB: r[rd] = r[rs] - r[rt];
                    FUNC_AND: r[rd] = r[rs] & r[rt];
                    FUNC_ORR: r[rd] = r[rs] | r[rt];
                    FUNC_WWD: exp_wwd.push_back(r[rs]);
                    FUNC_HLT: done = 1'b1;
                    default: ;
                endcase
            end
            OP_ADI: r[rt] = r[rs] + simm;
            OP_ORI: r[rt] = r[rs] | {8'h00, ins[7:0]};
            OP_LHI: r[rt] = {ins[7:0], 8'h00};
            OP_LWD: begin
                r[rt] = mem[addr[7:0]];
                exp_ld_addr.push_back(addr);
            end
            OP_SWD: begin
                mem[addr[7:0]] = r[rt];
                exp_st_addr.push_back(addr);
                exp_st_data.push_back(r[rt]);
            end
            OP_BNE: if (r[rs] != r[rt]) next_pc = pc + 16'd1 + simm;
            OP_BEQ: if (r[rs] == r[rt]) next_pc = pc + 16'd1 + simm;
            OP_JMP: next_pc = {pc[15:12], ins[11:0]}; // same page
            default: ;
        endcase
        pc = next_pc;
    end
endtask

`endif

//--- verif/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb import cpu_pkg::*; ();

    localparam logic [15:0] SEED     = 16'd72;
    localparam int PROG_LEN          = 40;
    localparam int TIMEOUT_FACTOR    = 10;
    localparam int NUM_RUNS          = 3;

    logic  clk;
    logic  reset;
    word_t i_addr, i_data, d_addr, d_wdata, d_rdata, output_port, num_inst;
    logic  d_read, d_write, output_valid, halted;

    logic [15:0] lfsr;
    word_t       imem [256];
    word_t       dmem [256];
    word_t       exp_wwd [$];
    word_t       exp_st_addr [$];
    word_t       exp_st_data [$];
    word_t       exp_ld_addr [$];
    word_t       exp_count;
    logic        checking;
    int          wwd_idx      = 0;
    int          st_idx       = 0;
    int          ld_idx       = 0;
    int          out_errors   = 0;
    int          store_errors = 0;
    int          load_errors  = 0;
    int          check_errors = 0;

    cpu_core dut_i (
        .clk, .reset, .i_addr, .i_data, .d_read, .d_write, .d_addr, .d_wdata,
        .d_rdata, .output_port, .output_valid, .num_inst, .halted
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t fill_word(input logic [7:0] a);
        return {a ^ 8'hA5, ~a};
    endfunction

    assign i_data  = imem[i_addr[7:0]]; // both memories answer in the same cycle
    assign d_rdata = dmem[d_addr[7:0]];

    always @(posedge clk) begin
        if (reset) begin
            for (int a = 0; a < 256; a++) begin
                dmem[a] <= fill_word(8'(a));
            end
        end else if (d_write) begin
            dmem[d_addr[7:0]] <= d_wdata;
        end
    end

    `include "cpu_model.svh"

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r    = {r[14:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic reg_idx_t pick_dest();
        reg_idx_t r;
        r = reg_idx_t'(lfsr_bits(2));
        return (r == 2'd0) ? 2'd1 : r; // r0 stays the memory base
    endfunction

    function automatic word_t encode_rtype(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                           logic [5:0] func);
        return {OP_RTYPE, rs, rt, rd, func};
    endfunction

    function automatic word_t encode_itype(opcode_t op, reg_idx_t rs, reg_idx_t rt,
                                           logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic gen_program();
        int         n;
        int         off;
        logic [2:0] kind;
        logic [1:0] sel;
        opcode_t    iop;
        reg_idx_t   s, t, d;
        logic [7:0] imm;
        for (int a = 0; a < 256; a++) begin
            imem[a] = encode_rtype(2'd0, 2'd0, 2'd0, FUNC_HLT);
        end
        imem[0] = encode_itype(OP_LHI, 2'd0, 2'd0, 8'h00);
        n = 1;
        while (n <= PROG_LEN) begin
            kind = 3'(lfsr_bits(3));
            s    = reg_idx_t'(lfsr_bits(2));
            t    = reg_idx_t'(lfsr_bits(2));
            d    = pick_dest();
            imm  = 8'(lfsr_bits(8));
            sel  = 2'(lfsr_bits(2));
            off  = 1 + int'(lfsr_bits(2));
            iop  = (sel == 2'd3) ? OP_LHI : ((sel == 2'd2) ? OP_ORI : OP_ADI);
            case (kind)
                3'd0, 3'd1: imem[n] = encode_rtype(s, t, d, 6'(sel));
                3'd2: imem[n] = encode_itype(iop, s, d, imm);
                3'd3: begin
                    imem[n] = encode_itype(OP_LWD, 2'd0, d, {4'h0, imm[3:0]});
                    n++;
                    imem[n] = encode_rtype(d, t, pick_dest(), FUNC_SUB); // load-use
                end
                3'd4: imem[n] = encode_itype(OP_SWD, 2'd0, t, {4'h0, imm[3:0]});
                3'd5: imem[n] = encode_itype(imm[7] ? OP_BEQ : OP_BNE, s, t, 8'(off));
                3'd6: imem[n] = {OP_JMP, 12'(n + 1 + off)};
                default: imem[n] = encode_rtype(s, 2'd0, 2'd0, FUNC_WWD);
            endcase
            n++;
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            imem[n] = encode_rtype(reg_idx_t'(r), 2'd0, 2'd0, FUNC_WWD);
            n++;
        end
        imem[n] = encode_rtype(2'd0, 2'd0, 2'd0, FUNC_HLT);
    endtask

    // output, store and load streams, checked mid-cycle
    always @(negedge clk) begin
        if (!checking) begin
            wwd_idx = 0;
            st_idx  = 0;
            ld_idx  = 0;
        end else begin
            if (output_valid) begin
                assert (wwd_idx < exp_wwd.size()) else begin
                    out_errors++;
                    $display("output_valid pulse beyond the %0d expected WWDs", exp_wwd.size());
                end
                if (wwd_idx < exp_wwd.size()) begin
                    assert (output_port == exp_wwd[wwd_idx]) else begin
                        out_errors++;
                        $display("mismatch output_port: got %h, expected %h",
                                 output_port, exp_wwd[wwd_idx]);
                    end
                end
                wwd_idx++;
            end
            if (d_write) begin
                assert (st_idx < exp_st_addr.size()) else begin
                    store_errors++;
                    $display("store beyond the %0d expected stores", exp_st_addr.size());
                end
                if (st_idx < exp_st_addr.size()) begin
                    assert (d_addr == exp_st_addr[st_idx]) else begin
                        store_errors++;
                        $display("mismatch d_addr: got %h, expected %h",
                                 d_addr, exp_st_addr[st_idx]);
                    end
                    assert (d_wdata == exp_st_data[st_idx]) else begin
                        store_errors++;
                        $display("mismatch d_wdata: got %h, expected %h",
                                 d_wdata, exp_st_data[st_idx]);
                    end
                end
                st_idx++;
            end
            if (d_read) begin
                assert (ld_idx < exp_ld_addr.size()) else begin
                    load_errors++;
                    $display("load beyond the %0d expected loads", exp_ld_addr.size());
                end
                if (ld_idx < exp_ld_addr.size()) begin
                    assert (d_addr == exp_ld_addr[ld_idx]) else begin
                        load_errors++;
                        $display("mismatch d_addr: got %h, expected %h",
                                 d_addr, exp_ld_addr[ld_idx]);
                    end
                end
                ld_idx++;
            end
        end
    end

    task automatic check_reset_state();
        assert (!d_read && !d_write && !output_valid && !halted) else begin
            check_errors++;
            $display("mismatch {d_read,d_write,output_valid,halted}: got %h, expected 0",
                     {d_read, d_write, output_valid, halted});
        end
        assert (num_inst == 16'd0) else begin
            check_errors++;
            $display("mismatch num_inst after reset: got %h, expected 0000", num_inst);
        end
    endtask

    task automatic check_end_state();
        assert (wwd_idx == exp_wwd.size()) else begin
            check_errors++;
            $display("saw %0d WWD outputs where %0d were expected", wwd_idx, exp_wwd.size());
        end
        assert (st_idx == exp_st_addr.size()) else begin
            check_errors++;
            $display("saw %0d stores where %0d were expected", st_idx, exp_st_addr.size());
        end
        assert (ld_idx == exp_ld_addr.size()) else begin
            check_errors++;
            $display("saw %0d loads where %0d were expected", ld_idx, exp_ld_addr.size());
        end
        for (int i = 0; i <= 10; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            assert (halted) else begin
                check_errors++;
                $display("halted dropped %0d cycles after HLT", i);
            end
            assert (num_inst == exp_count) else begin
                check_errors++;
                $display("mismatch num_inst: got %h, expected %h", num_inst, exp_count);
            end
        end
    endtask

    function automatic int assert_fails();
        return dut_i.cpu_assert_i.fail_rw + dut_i.cpu_assert_i.fail_halt
             + dut_i.cpu_assert_i.fail_count + dut_i.cpu_assert_i.fail_out;
    endfunction

    initial begin
        int limit;
        int cycles;
        reset    = 1'b1;
        checking = 1'b0;
        lfsr     = SEED;
        limit    = TIMEOUT_FACTOR * PROG_LEN + 20;
        for (int run = 0; run < NUM_RUNS; run++) begin
            gen_program();
            run_model();
            @(posedge clk);
            reset    <= 1'b1;
            checking <= 1'b0;
            repeat (4) @(posedge clk);
            reset    <= 1'b0;
            checking <= 1'b1;
            @(negedge clk);
            check_reset_state();
            cycles = 0;
            while (!halted && cycles < limit) begin
                @(negedge clk);
                cycles++;
            end
            if (!halted) begin
                check_errors++;
                $display("timeout: run %0d did not halt within %0d cycles", run, limit);
                break;
            end
            check_end_state();
        end
        $display("errors: %0d output, %0d store, %0d load, %0d other, %0d assertion",
                 out_errors, store_errors, load_errors, check_errors, assert_fails());
        if (out_errors + store_errors + load_errors + check_errors + assert_fails() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+verif
verilog/cpu_pkg.sv
verilog/pipe_reg.sv
verilog/decode_unit.sv
verilog/reg_file.sv
verilog/hazard_unit.sv
verilog/execute_unit.sv
verilog/cpu_core.sv
verif/cpu_assert.sv
verif/cpu_tb.sv

//--- Makefile
.PHONY: all lint clean

all: obj_dir/cpu_tb
	./obj_dir/cpu_tb +verilator+error+limit+100 | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

obj_dir/cpu_tb: build.f verilog/*.sv verif/*.sv verif/*.svh
	verilator --binary --assert --timescale 1ns/1ns -f build.f --top-module cpu_tb -o cpu_tb

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ns -f build.f --top-module cpu_tb

clean:
	rm -rf obj_dir sim.log
